// File: fabricIpTop.f
logic/fabricPkg.sv
logic/wbTarget_if.sv
logic/wbAddrDecode.sv
logic/fabricRegisters.sv
logic/fabricRam.sv
logic/busReturn.sv
logic/fabricIpTop.sv
tests/tbFabricIp.sv

// File: logic/busReturn.sv
// Read-data return, acknowledge merge and default timeout responder for unmapped windows
`timescale 1ns/1ps

module busReturn #(
    parameter int timeoutCount = 7
) (
    input  logic                wbClk_i,
    input  logic                rstN_i,
    wbTarget_if.monitor         regBus,
    wbTarget_if.monitor         ramBus,
    input  logic                unmappedCyc_i,
    input  fabricPkg::window_t  winSel_i,
    input  logic                wbStb_i,
    output fabricPkg::data_t    wbDat_o,
    output logic                wbAck_o
);

    localparam int                  cntWidth = $clog2(timeoutCount + 1);
    localparam logic [cntWidth-1:0] cntLast  = cntWidth'(timeoutCount - 1);

    fabricPkg::respState_t stateQ;
    logic [cntWidth-1:0]   cntQ;
    logic                  timeoutAck;

    // ----------------------------------------
    // Timeout FSM
    // ----------------------------------------
    always_ff @(posedge wbClk_i)
    begin
        if (!rstN_i)
        begin
            stateQ <= fabricPkg::RESP_IDLE;
            cntQ   <= '0;
        end
        else
        begin
            case (stateQ)
                fabricPkg::RESP_IDLE:
                begin
                    cntQ <= '0;
                    if (unmappedCyc_i && wbStb_i)
                    begin
                        stateQ <= fabricPkg::RESP_COUNT;
                    end
                end
                fabricPkg::RESP_COUNT:
                begin
                    if (!unmappedCyc_i)
                    begin
                        stateQ <= fabricPkg::RESP_IDLE;   // Master abandoned the cycle
                    end
                    else if (cntQ == cntLast)
                    begin
                        stateQ <= fabricPkg::RESP_DONE;
                    end
                    else
                    begin
                        cntQ <= cntQ + cntWidth'(1);
                    end
                end
                default:
                begin
                    stateQ <= fabricPkg::RESP_IDLE;   // Done lasts one cycle
                end
            endcase
        end
    end

    assign timeoutAck = (stateQ == fabricPkg::RESP_DONE);

    // Only one target can be selected, so a plain OR is enough
    assign wbAck_o = regBus.ack | ramBus.ack | timeoutAck;

    always_comb
    begin
        case (winSel_i)
            fabricPkg::REG_WINDOW: wbDat_o = regBus.datR;
            fabricPkg::RAM_WINDOW: wbDat_o = ramBus.datR;
            default:               wbDat_o = fabricPkg::BAD_READ_VALUE;
        endcase
    end

endmodule

// File: logic/fabricIpTop.sv
// Wishbone slave front end that ties decode, register and RAM targets and read return
`timescale 1ns/1ps

module fabricIpTop #(
    parameter int ramAdrWidth  = 8,    // 256 words
    parameter int timeoutCount = 7     // Unmapped access wait
) (
    input  logic                wbClk_i,
    input  logic                rstN_i,
    input  fabricPkg::addr_t    wbAdr_i,
    input  logic                wbCyc_i,
    input  logic                wbStb_i,
    input  logic                wbWe_i,
    input  fabricPkg::byteStb_t wbSel_i,
    input  fabricPkg::data_t    wbDat_i,
    output fabricPkg::data_t    wbDat_o,
    output logic                wbAck_o,
    output logic [7:0]          gpio_o
);

    localparam int regAdrWidth = $bits(fabricPkg::regAdr_t);

    logic               unmappedCyc;
    fabricPkg::window_t winSel;

    // ----------------------------------------
    // Target buses
    // ----------------------------------------
    wbTarget_if #(.ramAdrWidth(regAdrWidth)) regBus ();   // Register word offset
    wbTarget_if #(.ramAdrWidth(ramAdrWidth)) ramBus ();

    wbAddrDecode #(
        .ramAdrWidth    (ramAdrWidth)
    ) wbAddrDecode_inst (
        .wbAdr_i        (wbAdr_i),
        .wbCyc_i        (wbCyc_i),
        .wbStb_i        (wbStb_i),
        .wbWe_i         (wbWe_i),
        .wbSel_i        (wbSel_i),
        .wbDat_i        (wbDat_i),
        .regBus         (regBus.decoder),
        .ramBus         (ramBus.decoder),
        .unmappedCyc_o  (unmappedCyc),
        .winSel_o       (winSel)
    );

    // ----------------------------------------
    // Targets
    // ----------------------------------------
    fabricRegisters fabricRegisters_inst (
        .wbClk_i        (wbClk_i),
        .rstN_i         (rstN_i),
        .regBus         (regBus.target),
        .gpio_o         (gpio_o)
    );

    fabricRam #(
        .ramAdrWidth    (ramAdrWidth)
    ) fabricRam_inst (
        .wbClk_i        (wbClk_i),
        .rstN_i         (rstN_i),
        .ramBus         (ramBus.target)
    );

    // Read return and default timeout
    busReturn #(
        .timeoutCount   (timeoutCount)
    ) busReturn_inst (
        .wbClk_i        (wbClk_i),
        .rstN_i         (rstN_i),
        .regBus         (regBus.monitor),
        .ramBus         (ramBus.monitor),
        .unmappedCyc_i  (unmappedCyc),
        .winSel_i       (winSel),
        .wbStb_i        (wbStb_i),
        .wbDat_o        (wbDat_o),
        .wbAck_o        (wbAck_o)
    );

endmodule

// File: logic/fabricPkg.sv
// Fabric IP shared bus types, window map and register constants
package fabricPkg;

    // ----------------------------------------
    // Bus field types
    // ----------------------------------------
    typedef logic [16:0] addr_t;      // Host byte address, 128 KB aperture
    typedef logic [31:0] data_t;
    typedef logic [3:0]  byteStb_t;   // One strobe per data byte
    typedef logic [3:0]  window_t;    // Address bits 16 to 13
    typedef logic [6:0]  regAdr_t;    // Register word offset, address bits 8 to 2

    // ----------------------------------------
    // Window map, 8 KB per window
    // ----------------------------------------
    localparam int      WINDOW_LSB = 13;
    localparam window_t REG_WINDOW = 4'd0;    // Base 0x00000
    localparam window_t RAM_WINDOW = 4'd1;    // Base 0x02000

    // Register offsets inside the register window
    localparam regAdr_t REG_ID_ADR      = 7'h0;
    localparam regAdr_t REG_REV_ADR     = 7'h1;
    localparam regAdr_t REG_SCRATCH_ADR = 7'h2;
    localparam regAdr_t REG_GPIO_ADR    = 7'h3;

    // ----------------------------------------
    // Read constants
    // ----------------------------------------
    localparam data_t FABRIC_ID      = 32'h5A4D0001;
    localparam data_t FABRIC_REV     = 32'h00010000;
    localparam data_t REG_DEF_VALUE  = 32'hFABDEFAC;   // Undefined register offset
    localparam data_t BAD_READ_VALUE = 32'hBADFABAC;   // Unmapped window

    // Default timeout responder states
    typedef enum logic [1:0] {
        RESP_IDLE,
        RESP_COUNT,
        RESP_DONE
    } respState_t;

endpackage

// File: logic/fabricRam.sv
// Word-wide RAM target with byte-strobe writes and registered read and acknowledge
`timescale 1ns/1ps

module fabricRam #(
    parameter int ramAdrWidth = 8
) (
    input  logic        wbClk_i,
    input  logic        rstN_i,
    wbTarget_if.target  ramBus
);

    localparam int ramDepth = 2 ** ramAdrWidth;

    fabricPkg::data_t mem [ramDepth];
    fabricPkg::data_t rdDatQ;
    logic             ackQ;
    logic             access;

    assign access = ramBus.cyc & ramBus.stb & ~ackQ;

    // ----------------------------------------
    // Acknowledge
    // ----------------------------------------
    always_ff @(posedge wbClk_i)
    begin
        if (!rstN_i)
        begin
            ackQ <= 1'b0;
        end
        else
        begin
            ackQ <= access;
        end
    end

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    always_ff @(posedge wbClk_i)
    begin
        if (access)
        begin
            if (ramBus.we)
            begin
                for (int b = 0; b < $bits(fabricPkg::byteStb_t); b++)
                begin
                    if (ramBus.sel[b])
                    begin
                        mem[ramBus.adr][b*8 +: 8] <= ramBus.datW[b*8 +: 8];
                    end
                end
            end
            rdDatQ <= mem[ramBus.adr];   // Lands together with ack
        end
    end

    assign ramBus.ack  = ackQ;
    assign ramBus.datR = rdDatQ;

endmodule

// File: logic/fabricRegisters.sv
// Register target with ID, revision, byte-strobed scratch and GPIO output registers
`timescale 1ns/1ps

module fabricRegisters (
    input  logic        wbClk_i,
    input  logic        rstN_i,
    wbTarget_if.target  regBus,
    output logic [7:0]  gpio_o
);

    fabricPkg::data_t scratchQ;
    logic [7:0]       gpioQ;
    logic             ackQ;
    logic             access;     // Request seen, not yet acknowledged
    logic             wrEn;

    assign access = regBus.cyc & regBus.stb & ~ackQ;
    assign wrEn   = access & regBus.we;

    // ----------------------------------------
    // Acknowledge, one cycle per request
    // ----------------------------------------
    always_ff @(posedge wbClk_i)
    begin
        if (!rstN_i)
        begin
            ackQ <= 1'b0;
        end
        else
        begin
            ackQ <= access;
        end
    end

    assign regBus.ack = ackQ;

    // ----------------------------------------
    // Writable registers
    // ----------------------------------------
    always_ff @(posedge wbClk_i)
    begin
        if (!rstN_i)
        begin
            scratchQ <= '0;
            gpioQ    <= '0;
        end
        else if (wrEn)
        begin
            if (regBus.adr == fabricPkg::REG_SCRATCH_ADR)
            begin
                for (int b = 0; b < $bits(fabricPkg::byteStb_t); b++)
                begin
                    if (regBus.sel[b])
                    begin
                        scratchQ[b*8 +: 8] <= regBus.datW[b*8 +: 8];
                    end
                end
            end

            // Only lane 0 exists in the GPIO register
            if (regBus.adr == fabricPkg::REG_GPIO_ADR && regBus.sel[0])
            begin
                gpioQ <= regBus.datW[7:0];
            end
        end
    end

    assign gpio_o = gpioQ;

    // Read mux, held stable by the master through the ack cycle
    always_comb
    begin
        case (regBus.adr)
            fabricPkg::REG_ID_ADR:      regBus.datR = fabricPkg::FABRIC_ID;
            fabricPkg::REG_REV_ADR:     regBus.datR = fabricPkg::FABRIC_REV;
            fabricPkg::REG_SCRATCH_ADR: regBus.datR = scratchQ;
            fabricPkg::REG_GPIO_ADR:    regBus.datR = {24'h0, gpioQ};
            default:                    regBus.datR = fabricPkg::REG_DEF_VALUE;
        endcase
    end

endmodule

// File: logic/wbAddrDecode.sv
// Wishbone address decoder that selects the register, RAM or unmapped window
`timescale 1ns/1ps

module wbAddrDecode #(
    parameter int ramAdrWidth = 8
) (
    input  fabricPkg::addr_t    wbAdr_i,
    input  logic                wbCyc_i,
    input  logic                wbStb_i,
    input  logic                wbWe_i,
    input  fabricPkg::byteStb_t wbSel_i,
    input  fabricPkg::data_t    wbDat_i,
    wbTarget_if.decoder         regBus,
    wbTarget_if.decoder         ramBus,
    output logic                unmappedCyc_o,
    output fabricPkg::window_t  winSel_o
);

    logic regHit;
    logic ramHit;

    // ----------------------------------------
    // Window compare
    // ----------------------------------------
    assign winSel_o = wbAdr_i[fabricPkg::WINDOW_LSB +: $bits(fabricPkg::window_t)];

    assign regHit = (winSel_o == fabricPkg::REG_WINDOW);
    assign ramHit = (winSel_o == fabricPkg::RAM_WINDOW);

    // Per-target cycle selects
    assign regBus.cyc    = wbCyc_i & regHit;
    assign ramBus.cyc    = wbCyc_i & ramHit;
    assign unmappedCyc_o = wbCyc_i & ~regHit & ~ramHit;   // Ends in the timeout responder

    // ----------------------------------------
    // Shared request fields
    // ----------------------------------------
    assign regBus.stb  = wbStb_i;
    assign regBus.we   = wbWe_i;
    assign regBus.sel  = wbSel_i;
    assign regBus.datW = wbDat_i;

    assign ramBus.stb  = wbStb_i;
    assign ramBus.we   = wbWe_i;
    assign ramBus.sel  = wbSel_i;
    assign ramBus.datW = wbDat_i;

    // Word addresses, byte lanes dropped
    assign regBus.adr = wbAdr_i[2 +: $bits(fabricPkg::regAdr_t)];
    assign ramBus.adr = wbAdr_i[2 +: ramAdrWidth];

endmodule

// File: logic/wbTarget_if.sv
// Decoded Wishbone request to one target and the target's response back
`timescale 1ns/1ps

interface wbTarget_if #(
    parameter int ramAdrWidth = 8    // Word address width of the attached target
);

    logic                   cyc;     // Cycle select for this target only
    logic                   stb;
    logic                   we;
    fabricPkg::byteStb_t    sel;
    logic [ramAdrWidth-1:0] adr;     // Word address, already cut to target size
    fabricPkg::data_t       datW;
    fabricPkg::data_t       datR;
    logic                   ack;

    // Request side, driven by the address decoder
    modport decoder (
        output cyc, stb, we, sel, adr, datW
    );

    modport target (
        input  cyc, stb, we, sel, adr, datW,
        output datR, ack
    );

    // Read-return side only looks at the response
    modport monitor (
        input datR, ack
    );

endinterface

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir &&
verilator --binary --timing --assert -j 0 --top-module tbFabricIp \
    -f fabricIpTop.f -o simFabricIp &&
./obj_dir/simFabricIp | tee /dev/stderr | grep -q "^Verification passed$" &&
echo "Simulation PASSED" ||
{
    echo "Simulation FAILED"
    exit 1
}

// File: tests/tbFabricIp.sv
// Testbench for the Wishbone fabric front end, covering registers, RAM and unmapped windows
`timescale 1ns/1ps

module tbFabricIp;

    localparam int ramAdrWidth  = 8;
    localparam int timeoutCount = 7;
    localparam int ramDepth     = 2 ** ramAdrWidth;

    localparam int numScratch  = 16;
    localparam int numGpio     = 4;
    localparam int numRam      = 24;  // Each round is a fill, a strobed write and a read
    localparam int numUnmapped = 6;   // Each round is an unmapped read, write and a register read

    localparam int numTransfers   = 7 + 2 * (numScratch + numGpio) + 3 * numRam
                                    + 3 * numUnmapped;
    localparam int watchdogCycles = numTransfers * (timeoutCount + 3) + 50;

    logic                wbClk = 1'b0;
    logic                rstN;
    fabricPkg::addr_t    wbAdr;
    logic                wbCyc;
    logic                wbStb;
    logic                wbWe;
    fabricPkg::byteStb_t wbSel;
    fabricPkg::data_t    wbDatW;
    fabricPkg::data_t    wbDatR;
    logic                wbAck;
    logic [7:0]          gpio;

    logic [31:0]         lfsrState = 32'hcd9da49a;
    logic                ackPrev   = 1'b0;
    fabricPkg::data_t    ramRef [ramDepth];   // Reference RAM contents

    fabricIpTop #(
        .ramAdrWidth    (ramAdrWidth),
        .timeoutCount   (timeoutCount)
    ) fabricIpTop_inst (
        .wbClk_i        (wbClk),
        .rstN_i         (rstN),
        .wbAdr_i        (wbAdr),
        .wbCyc_i        (wbCyc),
        .wbStb_i        (wbStb),
        .wbWe_i         (wbWe),
        .wbSel_i        (wbSel),
        .wbDat_i        (wbDatW),
        .wbDat_o        (wbDatR),
        .wbAck_o        (wbAck),
        .gpio_o         (gpio)
    );

    always #5 wbClk = ~wbClk;   // 10 ns period

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic checkData(input string name, input fabricPkg::data_t expected,
                             input fabricPkg::data_t actual);
        assert (actual === expected)
        else abortRun($sformatf("Fail %s expected 0x%08h actual 0x%08h", name, expected, actual));
    endtask

    task automatic checkLatency(input string name, input int expected, input int actual);
        assert (actual == expected)
        else abortRun($sformatf("Fail %s ack latency expected %0d actual %0d",
                                name, expected, actual));
    endtask

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] result;
        logic        fb;
        result = '0;
        for (int i = 0; i < n; i++)
        begin
            fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            result    = {result[30:0], fb};
        end
        return result;
    endfunction

    function automatic fabricPkg::data_t laneMask(input fabricPkg::byteStb_t stb);
        fabricPkg::data_t m;
        for (int b = 0; b < 4; b++)
        begin
            m[b*8 +: 8] = {8{stb[b]}};
        end
        return m;
    endfunction

    // Strobed bytes come from the new word and the rest stay
    function automatic fabricPkg::data_t mergeBytes(input fabricPkg::data_t oldDat,
                                                    input fabricPkg::data_t newDat,
                                                    input fabricPkg::byteStb_t stb);
        return (oldDat & ~laneMask(stb)) | (newDat & laneMask(stb));
    endfunction

    function automatic fabricPkg::addr_t regAddr(input fabricPkg::regAdr_t offset);
        fabricPkg::addr_t a;
        a = '0;
        a[fabricPkg::WINDOW_LSB +: $bits(fabricPkg::window_t)] = fabricPkg::REG_WINDOW;
        a[2 +: $bits(fabricPkg::regAdr_t)] = offset;
        return a;
    endfunction

    function automatic fabricPkg::addr_t ramAddr(input logic [ramAdrWidth-1:0] wordAdr);
        fabricPkg::addr_t a;
        a = '0;
        a[fabricPkg::WINDOW_LSB +: $bits(fabricPkg::window_t)] = fabricPkg::RAM_WINDOW;
        a[2 +: ramAdrWidth] = wordAdr;
        return a;
    endfunction

    // ----------------------------------------
    // Wishbone classic master
    // ----------------------------------------
    task automatic busTransfer(input fabricPkg::addr_t adr, input logic we,
                               input fabricPkg::byteStb_t sel, input fabricPkg::data_t datW,
                               output fabricPkg::data_t datR, output int latency);
        logic ackSeen;
        ackSeen = 1'b0;
        latency = 0;
        @(negedge wbClk);
        wbAdr  = adr;
        wbWe   = we;
        wbSel  = sel;
        wbDatW = datW;
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        while (!ackSeen)
        begin
            @(negedge wbClk);
            latency++;   // Rising edges since stb
            if (wbAck)
            begin
                ackSeen = 1'b1;
                datR    = wbDatR;
            end
        end
        wbCyc = 1'b0;    // Dropped in the cycle after ack
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic writeWord(input string name, input fabricPkg::addr_t adr,
                             input fabricPkg::byteStb_t sel, input fabricPkg::data_t dat,
                             input int expLatency);
        fabricPkg::data_t unused;
        int               lat;
        busTransfer(adr, 1'b1, sel, dat, unused, lat);
        checkLatency(name, expLatency, lat);
    endtask

    task automatic readWord(input string name, input fabricPkg::addr_t adr,
                            input int expLatency, output fabricPkg::data_t dat);
        int lat;
        busTransfer(adr, 1'b0, 4'hF, '0, dat, lat);
        checkLatency(name, expLatency, lat);
    endtask

    // Ack stays one cycle wide and only inside a cycle
    always @(posedge wbClk)
    begin
        #1;
        if (rstN)
        begin
            assert (!(wbAck && !wbCyc)) else abortRun("Ack raised while cyc is low");
            assert (!(wbAck && ackPrev)) else abortRun("Ack held high for more than one cycle");
        end
        ackPrev = wbAck;
    end

    initial
    begin
        repeat (watchdogCycles) @(posedge wbClk);
        abortRun("Watchdog expired, the bus hung waiting for an acknowledge");
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial
    begin
        fabricPkg::data_t       rdDat;
        fabricPkg::data_t       wrDat;
        fabricPkg::data_t       scratchShadow;
        fabricPkg::byteStb_t    sel;
        fabricPkg::regAdr_t     offset;
        fabricPkg::window_t     win;
        fabricPkg::addr_t       adr;
        logic [ramAdrWidth-1:0] wordAdr;
        logic [ramAdrWidth-1:0] ramWritten [$];

        rstN   = 1'b0;
        wbAdr  = '0;
        wbCyc  = 1'b0;
        wbStb  = 1'b0;
        wbWe   = 1'b0;
        wbSel  = '0;
        wbDatW = '0;
        scratchShadow = '0;

        repeat (3) @(posedge wbClk);
        @(negedge wbClk);
        rstN = 1'b1;
        assert (wbAck == 1'b0) else abortRun("Ack high right after reset");
        checkData("gpio after reset", 32'h0, {24'h0, gpio});

        // Identification and undefined offsets
        readWord("id read", regAddr(fabricPkg::REG_ID_ADR), 1, rdDat);
        checkData("id read", fabricPkg::FABRIC_ID, rdDat);
        readWord("rev read", regAddr(fabricPkg::REG_REV_ADR), 1, rdDat);
        checkData("rev read", fabricPkg::FABRIC_REV, rdDat);
        offset = fabricPkg::regAdr_t'(4 + (takeBits(7) % 124));
        readWord("undefined read", regAddr(offset), 1, rdDat);
        checkData("undefined read", fabricPkg::REG_DEF_VALUE, rdDat);
        writeWord("id write", regAddr(fabricPkg::REG_ID_ADR), 4'hF, takeBits(32), 1);
        readWord("id after write", regAddr(fabricPkg::REG_ID_ADR), 1, rdDat);
        checkData("id after write", fabricPkg::FABRIC_ID, rdDat);
        writeWord("undefined write", regAddr(offset), 4'hF, takeBits(32), 1);
        readWord("undefined after write", regAddr(offset), 1, rdDat);
        checkData("undefined after write", fabricPkg::REG_DEF_VALUE, rdDat);

        for (int i = 0; i < numScratch; i++)
        begin
            wrDat = takeBits(32);
            sel   = fabricPkg::byteStb_t'(takeBits(4));
            writeWord("scratch write", regAddr(fabricPkg::REG_SCRATCH_ADR), sel, wrDat, 1);
            scratchShadow = mergeBytes(scratchShadow, wrDat, sel);
            readWord("scratch readback", regAddr(fabricPkg::REG_SCRATCH_ADR), 1, rdDat);
            checkData("scratch readback", scratchShadow, rdDat);
        end

        for (int i = 0; i < numGpio; i++)
        begin
            wrDat = takeBits(32);
            writeWord("gpio write", regAddr(fabricPkg::REG_GPIO_ADR), 4'hF, wrDat, 1);
            checkData("gpio at ack", {24'h0, wrDat[7:0]}, {24'h0, gpio});
            @(negedge wbClk);
            checkData("gpio after ack", {24'h0, wrDat[7:0]}, {24'h0, gpio});
            readWord("gpio readback", regAddr(fabricPkg::REG_GPIO_ADR), 1, rdDat);
            checkData("gpio readback", {24'h0, wrDat[7:0]}, rdDat);
        end

        // RAM words filled whole before the strobed write
        for (int i = 0; i < numRam; i++)
        begin
            wordAdr = ramAdrWidth'(takeBits(ramAdrWidth));
            wrDat   = takeBits(32);
            writeWord("ram fill", ramAddr(wordAdr), 4'hF, wrDat, 1);
            ramRef[wordAdr] = wrDat;
            sel     = fabricPkg::byteStb_t'(takeBits(4));
            wrDat   = takeBits(32);
            writeWord("ram write", ramAddr(wordAdr), sel, wrDat, 1);
            ramRef[wordAdr] = mergeBytes(ramRef[wordAdr], wrDat, sel);
            ramWritten.push_back(wordAdr);
        end
        for (int i = 0; i < ramWritten.size(); i++)
        begin
            wordAdr = ramWritten[i];
            readWord("ram read", ramAddr(wordAdr), 1, rdDat);
            checkData("ram read", ramRef[wordAdr], rdDat);
        end

        for (int i = 0; i < numUnmapped; i++)
        begin
            win = fabricPkg::window_t'(takeBits(4));
            if (win < 4'd2)
            begin
                win = win + 4'd2;   // Skip the register and RAM windows
            end
            adr = {win, 13'(takeBits(13))};
            readWord("unmapped read", adr, timeoutCount + 1, rdDat);
            checkData("unmapped read", fabricPkg::BAD_READ_VALUE, rdDat);
            writeWord("unmapped write", adr, 4'hF, takeBits(32), timeoutCount + 1);
            readWord("register after unmapped", regAddr(fabricPkg::REG_REV_ADR), 1, rdDat);
            checkData("register after unmapped", fabricPkg::FABRIC_REV, rdDat);
        end

        @(negedge wbClk);
        $display("Verification passed");
        $finish;
    end

endmodule
